// File: rv32_exec.f
+incdir+source
source/rv32_isa_pkg.sv
source/rv32_core_pkg.sv
source/rv32_regfile.sv
source/rv32_idu.sv
source/rv32_lsu.sv
source/rv32_exu.sv
source/rv32_exec_top.sv
verif/rv32_exec_chk.sv
verif/rv32_exec_tb.sv

// File: Makefile
SIM = obj_dir/rv32_exec_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f rv32_exec.f --top-module rv32_exec_tb -o rv32_exec_sim

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

// File: verif/rv32_exec_tb.sv
`timescale 1ns/1ps

module rv32_exec_tb;

  localparam int TIMEOUT = 50;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] inst_i, pc_i, wb_dat_i;
  logic        inst_valid_i, wb_ack_i;
  logic        inst_ready_o, commit_valid_o, commit_illegal_o;
  logic [4:0]  commit_rd_o;
  logic [31:0] commit_data_o, commit_next_pc_o;
  logic        wb_cyc_o, wb_stb_o, wb_we_o;
  logic [31:0] wb_adr_o, wb_dat_o;

  logic [31:0] mem [64];
  logic [31:0] ref_mem [64];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  logic [31:0] rng_state = 32'h086e_069c;
  logic [31:0] prog_inst [$];
  bit          prog_ill [$];
  logic [31:0] prog_pc [$];
  int          wb_count;
  logic [31:0] last_adr;

  // Reference model result for one instruction
  logic        exp_we;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data, exp_npc, exp_addr;
  int          exp_mem;

  // Expected commit fields per table row, in program order
  bit          tab_we [$];
  logic [4:0]  tab_rd [$];
  logic [31:0] tab_data [$];
  logic [31:0] tab_npc [$];
  logic [31:0] tab_addr [$];
  int          tab_mem [$];

  rv32_exec_top i_dut (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd, int opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_s(int imm, int rs2, int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(int imm, int rd, int opc);
    return {imm[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic add_entry(input logic [31:0] inst, input bit ill);
    prog_inst.push_back(inst);
    prog_ill.push_back(ill);
  endtask

  function automatic logic [31:0] alu(logic [2:0] f3, logic alt, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Reference model of one instruction, working from the ISA encoding
  task automatic predict(input logic [31:0] ins);
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j;
    logic        cond;
    f3 = ins[14:12];
    a = ref_regs[ins[19:15]];
    b = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    exp_rd = ins[11:7];
    exp_we = 1'b0;
    exp_mem = 0;
    exp_data = '0;
    exp_addr = '0;
    exp_npc = ref_pc + 32'd4;
    case (ins[6:0])
      7'h37: {exp_we, exp_data} = {1'b1, ins[31:12], 12'b0};
      7'h17: {exp_we, exp_data} = {1'b1, ref_pc + {ins[31:12], 12'b0}};
      7'h6f: begin
        {exp_we, exp_data} = {1'b1, ref_pc + 32'd4};
        exp_npc = ref_pc + imm_j;
      end
      7'h67: begin
        {exp_we, exp_data} = {1'b1, ref_pc + 32'd4};
        exp_npc = (a + imm_i) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          default: cond = (a >= b);
        endcase
        if (cond) exp_npc = ref_pc + imm_b;
      end
      7'h03: begin
        if (f3 == 3'd2) begin
          exp_mem = 1;
          exp_we = 1'b1;
          exp_addr = a + imm_i;
          exp_data = ref_mem[exp_addr[7:2]];
        end
      end
      7'h23: begin
        if (f3 == 3'd2) begin
          exp_mem = 2;
          exp_addr = a + imm_s;
          exp_data = b;
        end
      end
      7'h13: {exp_we, exp_data} = {1'b1, alu(f3, f3 == 3'd5 && ins[30], a, imm_i)};
      7'h33: begin
        if (ins[31:25] == 7'h00 || ins[31:25] == 7'h20) begin
          {exp_we, exp_data} = {1'b1, alu(f3, ins[30], a, b)};
        end
      end
      default: exp_we = 1'b0;
    endcase
  endtask

  // Runs the reference model over the whole table in program order
  task automatic build_expected();
    for (int k = 0; k < prog_inst.size(); k++) begin
      predict(prog_inst[k]);
      prog_pc.push_back(ref_pc);
      tab_we.push_back(exp_we);
      tab_rd.push_back(exp_rd);
      tab_data.push_back(exp_data);
      tab_npc.push_back(exp_npc);
      tab_addr.push_back(exp_addr);
      tab_mem.push_back(exp_mem);
      if (exp_we && exp_rd != 0) ref_regs[exp_rd] = exp_data;
      if (exp_mem == 2) ref_mem[exp_addr[7:2]] = exp_data;
      ref_pc = exp_npc;
    end
  endtask

  // Feeds the table without waiting for commits, so the decode unit can hold
  // the next instruction while the execute unit is still busy
  task automatic issue_all();
    int t;
    for (int k = 0; k < prog_inst.size(); k++) begin
      repeat (int'(next_rand() % 3)) begin
        @(posedge clk);
        #1;
      end
      inst_i = prog_inst[k];
      pc_i = prog_pc[k];
      inst_valid_i = 1'b1;
      t = 0;
      while (!inst_ready_o) begin
        @(posedge clk);
        #1;
        t = t + 1;
        if (t > TIMEOUT) fail_run("timeout waiting for inst_ready_o");
      end
      @(posedge clk);
      #1;
      inst_valid_i = 1'b0;
    end
  endtask

  task automatic check_commits();
    int t;
    int n_wb;
    n_wb = 0;
    for (int k = 0; k < prog_inst.size(); k++) begin
      t = 0;
      do begin
        @(posedge clk);
        #1;
        t = t + 1;
        if (t > TIMEOUT) fail_run("timeout waiting for commit_valid_o");
      end while (!commit_valid_o);
      check_val("commit_illegal_o", {31'b0, commit_illegal_o}, {31'b0, prog_ill[k]});
      check_val("commit_next_pc_o", commit_next_pc_o, tab_npc[k]);
      if (tab_we[k]) begin
        check_val("commit_rd_o", {27'b0, commit_rd_o}, {27'b0, tab_rd[k]});
        check_val("commit_data_o", commit_data_o, tab_data[k]);
      end
      check_val("wb_cycles", wb_count - n_wb, (tab_mem[k] != 0) ? 1 : 0);
      if (tab_mem[k] != 0) check_val("wb_adr_o", last_adr, tab_addr[k]);
      n_wb = wb_count;
    end
  endtask

  // Wishbone slave with a random answer delay
  initial begin
    int delay;
    wb_ack_i = 1'b0;
    wb_dat_i = '0;
    wb_count = 0;
    forever begin
      @(posedge clk);
      #1;
      if (wb_cyc_o && wb_stb_o) begin
        delay = int'(next_rand() % 4);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        if (wb_adr_o[31:8] != '0) fail_run("Wishbone address outside the memory model");
        if (wb_we_o) mem[wb_adr_o[7:2]] = wb_dat_o;
        else wb_dat_i = mem[wb_adr_o[7:2]];
        last_adr = wb_adr_o;
        wb_count++;
        wb_ack_i = 1'b1;
        @(posedge clk);
        #1;
        wb_ack_i = 1'b0;
      end
    end
  end

  initial begin
    rst = 1'b1;
    inst_i = '0;
    pc_i = '0;
    inst_valid_i = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    ref_pc = 32'h100;

    add_entry(enc_u(32'h80000, 1, 7'h37), 0);
    add_entry(enc_i(-16, 0, 0, 2, 7'h13), 0);
    add_entry(enc_i(5, 0, 0, 3, 7'h13), 0);
    add_entry(enc_u(32'h12345, 4, 7'h17), 0);
    add_entry(enc_i(32'h402, 2, 5, 5, 7'h13), 0);
    add_entry(enc_i(2, 2, 5, 6, 7'h13), 0);
    add_entry(enc_r(0, 3, 2, 2, 7, 7'h33), 0);
    add_entry(enc_r(0, 3, 2, 3, 8, 7'h33), 0);
    add_entry(enc_r(32'h20, 2, 3, 0, 9, 7'h33), 0);
    add_entry(enc_i(32'h0ff, 2, 4, 10, 7'h13), 0);
    add_entry(enc_r(0, 3, 1, 6, 11, 7'h33), 0);
    add_entry(enc_r(0, 3, 2, 7, 12, 7'h33), 0);
    add_entry(enc_r(0, 3, 3, 1, 13, 7'h33), 0);
    add_entry(enc_r(32'h20, 3, 1, 5, 14, 7'h33), 0);
    add_entry(enc_r(0, 3, 1, 5, 15, 7'h33), 0);
    add_entry(enc_i(-1, 2, 2, 16, 7'h13), 0);
    add_entry(enc_i(-1, 3, 3, 17, 7'h13), 0);
    add_entry(enc_i(7, 3, 0, 0, 7'h13), 0);
    add_entry(enc_r(0, 3, 0, 0, 19, 7'h33), 0);
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      add_entry(enc_b(8, 3, 2, f), 0);
      add_entry(enc_b(-12, 2, 3, f), 0);
    end
    add_entry(enc_j(16, 20), 0);
    add_entry(enc_i(3, 20, 0, 21, 7'h67), 0);
    add_entry(enc_i(32'h40, 0, 0, 22, 7'h13), 0);
    add_entry(enc_s(8, 9, 22), 0);
    add_entry(enc_i(8, 22, 2, 23, 7'h03), 0);
    add_entry(enc_r(0, 3, 23, 0, 24, 7'h33), 0);
    add_entry(enc_s(-4, 1, 22), 0);
    add_entry(enc_i(-4, 22, 2, 25, 7'h03), 0);
    add_entry(enc_i(32'h10, 0, 2, 26, 7'h03), 0);
    add_entry(32'h0000_0073, 1);
    add_entry(enc_i(0, 22, 0, 3, 7'h03), 1);
    add_entry(enc_r(0, 3, 2, 0, 3, 7'h0b), 1);
    add_entry(enc_r(1, 3, 2, 0, 3, 7'h33), 1);
    add_entry(enc_i(0, 0, 1, 0, 7'h0f), 0);
    add_entry(enc_r(0, 0, 3, 0, 28, 7'h33), 0);

    build_expected();

    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    fork
      issue_all();
      check_commits();
    join

    for (int i = 0; i < 64; i++) check_val($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: verif/rv32_exec_chk.sv
`timescale 1ns/1ps

module rv32_exec_chk (
  input logic        clk,
  input logic        rst,
  input logic        inst_ready_o,
  input logic        commit_valid_o,
  input logic        wb_cyc_o,
  input logic        wb_stb_o,
  input logic        wb_we_o,
  input logic [31:0] wb_adr_o,
  input logic [31:0] wb_dat_o,
  input logic        wb_ack_i
);

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb_o |-> wb_cyc_o)
    else $error("wb_stb_o high outside a Wishbone cycle");

  // A pending request keeps its address, data and direction until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc_o && wb_stb_o && !wb_ack_i) |=>
      ($stable(wb_adr_o) && $stable(wb_dat_o) && $stable(wb_we_o)))
    else $error("Wishbone request changed before ack");

  a_commit_pulse: assert property (@(posedge clk) disable iff (rst)
    commit_valid_o |=> !commit_valid_o)
    else $error("commit_valid_o high for two cycles");

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |-> (!wb_cyc_o && !wb_stb_o && !commit_valid_o && inst_ready_o))
    else $error("control outputs not idle after reset");

endmodule

bind rv32_exec_top rv32_exec_chk i_chk (.*);

// File: source/rv32_exec_top.sv
`timescale 1ns/1ps
`include "rv32_config.svh"

module rv32_exec_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [31:0]           inst_i,
  input  logic [`RV32_XLEN-1:0] pc_i,
  input  logic                  inst_valid_i,
  output logic                  inst_ready_o,
  output logic                  commit_valid_o,
  output logic [4:0]            commit_rd_o,
  output logic [`RV32_XLEN-1:0] commit_data_o,
  output logic [`RV32_XLEN-1:0] commit_next_pc_o,
  output logic                  commit_illegal_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [`RV32_XLEN-1:0] wb_adr_o,
  output logic [`RV32_XLEN-1:0] wb_dat_o,
  input  logic [`RV32_XLEN-1:0] wb_dat_i,
  input  logic                  wb_ack_i
);
  import rv32_core_pkg::*;

  logic                  dec_valid, exu_ready;
  logic [4:0]            rs1, rs2, rd;
  logic [`RV32_XLEN-1:0] rdata1, rdata2;
  logic [`RV32_XLEN-1:0] op1, op2, jbase, imm, dec_pc;
  alu_op_e               alu_op;
  mem_op_e               mem_op;
  logic                  rd_we, jump, branch, illegal;
  logic                  rf_we;
  logic [4:0]            rf_waddr;
  logic [`RV32_XLEN-1:0] rf_wdata;
  logic                  mem_req, mem_we, mem_done;
  logic [`RV32_XLEN-1:0] mem_addr, mem_wdata, mem_rdata;

  rv32_idu i_idu (
    .clk, .rst,
    .inst_i, .pc_i,
    .valid_i(inst_valid_i), .ready_o(inst_ready_o),
    .valid_o(dec_valid), .ready_i(exu_ready),
    .rs1_o(rs1), .rs2_o(rs2), .rdata1_i(rdata1), .rdata2_i(rdata2),
    .op1_o(op1), .op2_o(op2), .alu_op_o(alu_op), .jbase_o(jbase), .imm_o(imm),
    .pc_o(dec_pc), .rd_o(rd), .rd_we_o(rd_we), .jump_o(jump), .branch_o(branch),
    .mem_op_o(mem_op), .illegal_o(illegal)
  );

  rv32_exu i_exu (
    .clk, .rst,
    .valid_i(dec_valid), .ready_o(exu_ready),
    .op1_i(op1), .op2_i(op2), .alu_op_i(alu_op), .jbase_i(jbase), .imm_i(imm),
    .pc_i(dec_pc), .rd_i(rd), .rd_we_i(rd_we), .jump_i(jump), .branch_i(branch),
    .mem_op_i(mem_op), .illegal_i(illegal),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_we_o(mem_we),
    .mem_wdata_o(mem_wdata), .mem_done_i(mem_done), .mem_rdata_i(mem_rdata),
    .commit_valid_o, .commit_rd_o, .commit_data_o, .commit_next_pc_o, .commit_illegal_o
  );

  rv32_lsu i_lsu (
    .clk, .rst,
    .req_i(mem_req), .addr_i(mem_addr), .we_i(mem_we), .wdata_i(mem_wdata),
    .done_o(mem_done), .rdata_o(mem_rdata),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i
  );

  rv32_regfile i_regfile (
    .clk,
    .rs1_i(rs1), .rs2_i(rs2), .rdata1_o(rdata1), .rdata2_o(rdata2),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

endmodule

// File: source/rv32_exu.sv
`timescale 1ns/1ps
`include "rv32_config.svh"

module rv32_exu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   valid_i,
  output logic                   ready_o,
  input  logic [`RV32_XLEN-1:0]  op1_i,
  input  logic [`RV32_XLEN-1:0]  op2_i,
  input  rv32_core_pkg::alu_op_e alu_op_i,
  input  logic [`RV32_XLEN-1:0]  jbase_i,
  input  logic [`RV32_XLEN-1:0]  imm_i,
  input  logic [`RV32_XLEN-1:0]  pc_i,
  input  logic [4:0]             rd_i,
  input  logic                   rd_we_i,
  input  logic                   jump_i,
  input  logic                   branch_i,
  input  rv32_core_pkg::mem_op_e mem_op_i,
  input  logic                   illegal_i,
  output logic                   rf_we_o,
  output logic [4:0]             rf_waddr_o,
  output logic [`RV32_XLEN-1:0]  rf_wdata_o,
  output logic                   mem_req_o,
  output logic [`RV32_XLEN-1:0]  mem_addr_o,
  output logic                   mem_we_o,
  output logic [`RV32_XLEN-1:0]  mem_wdata_o,
  input  logic                   mem_done_i,
  input  logic [`RV32_XLEN-1:0]  mem_rdata_i,
  output logic                   commit_valid_o,
  output logic [4:0]             commit_rd_o,
  output logic [`RV32_XLEN-1:0]  commit_data_o,
  output logic [`RV32_XLEN-1:0]  commit_next_pc_o,
  output logic                   commit_illegal_o
);
  import rv32_core_pkg::*;

  localparam int SHW = $clog2(`RV32_XLEN);

  typedef enum logic [1:0] {S_IDLE, S_COMMIT, S_MEM} state_e;

  state_e                state_q;
  logic                  accept;
  logic                  taken;
  logic [SHW-1:0]        shamt;
  logic [`RV32_XLEN-1:0] alu_res, target, next_pc;
  logic [`RV32_XLEN-1:0] result_q, next_pc_q, addr_q, wdata_q;
  logic [4:0]            rd_q;
  logic                  we_q, illegal_q, mem_we_q, req_q;

  assign accept = valid_i && ready_o;
  assign shamt  = op2_i[SHW-1:0];

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  alu_res = op1_i + op2_i;
      ALU_SUB:  alu_res = op1_i - op2_i;
      ALU_SLL:  alu_res = op1_i << shamt;
      ALU_SRL:  alu_res = op1_i >> shamt;
      ALU_SRA:  alu_res = $signed(op1_i) >>> shamt;
      ALU_XOR:  alu_res = op1_i ^ op2_i;
      ALU_OR:   alu_res = op1_i | op2_i;
      ALU_AND:  alu_res = op1_i & op2_i;
      ALU_SLT,
      ALU_LT:   alu_res = `RV32_XLEN'($signed(op1_i) < $signed(op2_i));
      ALU_SLTU,
      ALU_LTU:  alu_res = `RV32_XLEN'(op1_i < op2_i);
      ALU_GE:   alu_res = `RV32_XLEN'($signed(op1_i) >= $signed(op2_i));
      ALU_GEU:  alu_res = `RV32_XLEN'(op1_i >= op2_i);
      ALU_EQ:   alu_res = `RV32_XLEN'(op1_i == op2_i);
      ALU_NE:   alu_res = `RV32_XLEN'(op1_i != op2_i);
      default:  alu_res = '0;
    endcase
  end

  // A branch takes its decision from bit 0 of the comparison
  assign taken   = jump_i || (branch_i && alu_res[0]);
  assign target  = jbase_i + imm_i;
  assign next_pc = taken ? {target[`RV32_XLEN-1:1], target[0] & ~jump_i}
                         : pc_i + `RV32_XLEN'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      req_q   <= 1'b0;
    end else begin
      req_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept && mem_op_i != MEM_NONE) begin
            state_q <= S_MEM;
            req_q   <= 1'b1;
          end else if (accept) begin
            state_q <= S_COMMIT;
          end
        end
        S_COMMIT: state_q <= S_IDLE;
        S_MEM: begin
          if (mem_done_i) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_q  <= alu_res;
      next_pc_q <= next_pc;
      rd_q      <= rd_i;
      we_q      <= rd_we_i;
      illegal_q <= illegal_i;
      addr_q    <= op1_i + imm_i;
      wdata_q   <= op2_i;
      mem_we_q  <= (mem_op_i == MEM_STORE);
    end
  end

  // Idle only, so a dependent instruction decodes after the write lands
  assign ready_o = (state_q == S_IDLE);

  assign commit_valid_o   = (state_q == S_COMMIT) || (state_q == S_MEM && mem_done_i);
  assign commit_data_o    = (state_q == S_MEM) ? (mem_we_q ? wdata_q : mem_rdata_i) : result_q;
  assign commit_rd_o      = rd_q;
  assign commit_next_pc_o = next_pc_q;
  assign commit_illegal_o = illegal_q;

  assign rf_we_o    = commit_valid_o && we_q;
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = commit_data_o;

  assign mem_req_o   = req_q;
  assign mem_addr_o  = addr_q;
  assign mem_we_o    = mem_we_q;
  assign mem_wdata_o = wdata_q;

endmodule

// File: source/rv32_lsu.sv
`timescale 1ns/1ps
`include "rv32_config.svh"

module rv32_lsu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_i,
  input  logic [`RV32_XLEN-1:0] addr_i,
  input  logic                  we_i,
  input  logic [`RV32_XLEN-1:0] wdata_i,
  output logic                  done_o,
  output logic [`RV32_XLEN-1:0] rdata_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [`RV32_XLEN-1:0] wb_adr_o,
  output logic [`RV32_XLEN-1:0] wb_dat_o,
  input  logic [`RV32_XLEN-1:0] wb_dat_i,
  input  logic                  wb_ack_i
);
  logic                  cyc_q;
  logic                  done_q;
  logic                  we_q;
  logic [`RV32_XLEN-1:0] adr_q;
  logic [`RV32_XLEN-1:0] dat_q;
  logic [`RV32_XLEN-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!cyc_q && req_i) begin
        cyc_q <= 1'b1;
      end else if (cyc_q && wb_ack_i) begin
        cyc_q  <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!cyc_q && req_i) begin
      adr_q <= addr_i;
      dat_q <= wdata_i;
      we_q  <= we_i;
    end
    if (cyc_q && wb_ack_i && !we_q) rdata_q <= wb_dat_i;
  end

  // Classic single transfers, so strobe and cycle are the same register
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign done_o   = done_q;
  assign rdata_o  = rdata_q;

endmodule

// File: source/rv32_idu.sv
`timescale 1ns/1ps
`include "rv32_config.svh"

module rv32_idu (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [31:0]            inst_i,
  input  logic [`RV32_XLEN-1:0]  pc_i,
  input  logic                   valid_i,
  output logic                   ready_o,
  output logic                   valid_o,
  input  logic                   ready_i,
  output logic [4:0]             rs1_o,
  output logic [4:0]             rs2_o,
  input  logic [`RV32_XLEN-1:0]  rdata1_i,
  input  logic [`RV32_XLEN-1:0]  rdata2_i,
  output logic [`RV32_XLEN-1:0]  op1_o,
  output logic [`RV32_XLEN-1:0]  op2_o,
  output rv32_core_pkg::alu_op_e alu_op_o,
  output logic [`RV32_XLEN-1:0]  jbase_o,
  output logic [`RV32_XLEN-1:0]  imm_o,
  output logic [`RV32_XLEN-1:0]  pc_o,
  output logic [4:0]             rd_o,
  output logic                   rd_we_o,
  output logic                   jump_o,
  output logic                   branch_o,
  output rv32_core_pkg::mem_op_e mem_op_o,
  output logic                   illegal_o
);
  import rv32_isa_pkg::*;
  import rv32_core_pkg::*;

  typedef enum logic {S_IDLE, S_WAIT_READY} state_e;

  state_e                state_q;
  inst_u                 inst_q;
  logic [`RV32_XLEN-1:0] pc_q;
  logic [`RV32_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (valid_i) state_q <= S_WAIT_READY;
        end
        S_WAIT_READY: begin
          if (ready_i) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // The latched word stays put until the execute unit takes it
  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      inst_q <= inst_i;
      pc_q   <= pc_i;
    end
  end

  assign ready_o = (state_q == S_IDLE);
  assign valid_o = (state_q == S_WAIT_READY);
  assign rs1_o   = inst_q.r.rs1;
  assign rs2_o   = inst_q.r.rs2;
  assign rd_o    = inst_q.r.rd;
  assign pc_o    = pc_q;

  assign imm_i = `RV32_XLEN'($signed(inst_q.i.imm_11_0));
  assign imm_s = `RV32_XLEN'($signed({inst_q.s.imm_11_5, inst_q.s.imm_4_0}));
  assign imm_b = `RV32_XLEN'($signed({inst_q.b.imm_12, inst_q.b.imm_11, inst_q.b.imm_10_5,
                                      inst_q.b.imm_4_1, 1'b0}));
  assign imm_u = `RV32_XLEN'($signed({inst_q.u.imm_31_12, 12'b0}));
  assign imm_j = `RV32_XLEN'($signed({inst_q.j.imm_20, inst_q.j.imm_19_12, inst_q.j.imm_11,
                                      inst_q.j.imm_10_1, 1'b0}));

  always_comb begin
    op1_o     = rdata1_i;
    op2_o     = rdata2_i;
    alu_op_o  = ALU_ADD;
    jbase_o   = pc_q;
    imm_o     = '0;
    rd_we_o   = 1'b0;
    jump_o    = 1'b0;
    branch_o  = 1'b0;
    mem_op_o  = MEM_NONE;
    illegal_o = 1'b0;
    case (inst_q.r.opcode)
      OPC_LUI: begin
        op1_o   = '0;
        op2_o   = imm_u;
        imm_o   = imm_u;
        rd_we_o = 1'b1;
      end
      OPC_AUIPC: begin
        op1_o   = pc_q;
        op2_o   = imm_u;
        imm_o   = imm_u;
        rd_we_o = 1'b1;
      end
      OPC_JAL: begin
        op1_o   = pc_q;
        op2_o   = `RV32_XLEN'(4);
        imm_o   = imm_j;
        jump_o  = 1'b1;
        rd_we_o = 1'b1;
      end
      OPC_JALR: begin
        op1_o     = pc_q;
        op2_o     = `RV32_XLEN'(4);
        jbase_o   = rdata1_i;
        imm_o     = imm_i;
        jump_o    = 1'b1;
        rd_we_o   = 1'b1;
        illegal_o = (inst_q.i.funct3 != F3_JALR);
      end
      OPC_BRANCH: begin
        imm_o    = imm_b;
        branch_o = 1'b1;
        case (inst_q.b.funct3)
          F3_BEQ:  alu_op_o = ALU_EQ;
          F3_BNE:  alu_op_o = ALU_NE;
          F3_BLT:  alu_op_o = ALU_LT;
          F3_BGE:  alu_op_o = ALU_GE;
          F3_BLTU: alu_op_o = ALU_LTU;
          F3_BGEU: alu_op_o = ALU_GEU;
          default: illegal_o = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        op2_o     = imm_i;
        imm_o     = imm_i;
        mem_op_o  = MEM_LOAD;
        rd_we_o   = 1'b1;
        illegal_o = (inst_q.i.funct3 != F3_WORD);
      end
      OPC_STORE: begin
        imm_o     = imm_s;
        mem_op_o  = MEM_STORE;
        illegal_o = (inst_q.s.funct3 != F3_WORD);
      end
      OPC_OP_IMM: begin
        op2_o    = imm_i;
        imm_o    = imm_i;
        alu_op_o = alu_op_e'({inst_q.r.funct3 == 3'b101 && inst_q.r.funct7[5],
                              inst_q.r.funct3});
        rd_we_o  = 1'b1;
      end
      OPC_OP: begin
        alu_op_o  = alu_op_e'({inst_q.r.funct7[5], inst_q.r.funct3});
        rd_we_o   = 1'b1;
        // Only funct7 values 0 and 0x20 belong to the base set
        illegal_o = ((inst_q.r.funct7 & 7'b1011111) != '0);
      end
      OPC_MISC_MEM: illegal_o = (inst_q.i.funct3 != F3_FENCEI);
      OPC_SYSTEM:   illegal_o = 1'b1;
      default:      illegal_o = 1'b1;
    endcase
    if (illegal_o) begin
      rd_we_o  = 1'b0;
      jump_o   = 1'b0;
      branch_o = 1'b0;
      mem_op_o = MEM_NONE;
    end
  end

endmodule

// File: source/rv32_regfile.sv
`timescale 1ns/1ps
`include "rv32_config.svh"

module rv32_regfile (
  input  logic                  clk,
  input  logic [4:0]            rs1_i,
  input  logic [4:0]            rs2_i,
  output logic [`RV32_XLEN-1:0] rdata1_o,
  output logic [`RV32_XLEN-1:0] rdata2_o,
  input  logic                  we_i,
  input  logic [4:0]            waddr_i,
  input  logic [`RV32_XLEN-1:0] wdata_i
);
  localparam int AW = $clog2(`RV32_NREGS);

  logic [`RV32_XLEN-1:0] regs [`RV32_NREGS];

  // Register numbers past the end of a reduced file read as zero
  assign rdata1_o = (rs1_i != '0 && rs1_i < `RV32_NREGS) ? regs[rs1_i[AW-1:0]] : '0;
  assign rdata2_o = (rs2_i != '0 && rs2_i < `RV32_NREGS) ? regs[rs2_i[AW-1:0]] : '0;

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0 && waddr_i < `RV32_NREGS) begin
      regs[waddr_i[AW-1:0]] <= wdata_i;
    end
  end

endmodule

// File: source/rv32_core_pkg.sv
package rv32_core_pkg;

  // Arithmetic codes are {funct7[5], funct3}, comparisons fill the unused codes
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_NE   = 4'b1001,
    ALU_EQ   = 4'b1010,
    ALU_GE   = 4'b1011,
    ALU_LT   = 4'b1100,
    ALU_SRA  = 4'b1101,
    ALU_LTU  = 4'b1110,
    ALU_GEU  = 4'b1111
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'b00,
    MEM_LOAD  = 2'b01,
    MEM_STORE = 2'b10
  } mem_op_e;

endpackage

// File: source/rv32_isa_pkg.sv
package rv32_isa_pkg;

  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_LOAD     = 7'b0000011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Only full words are supported by LW and SW
  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_JALR   = 3'b000;
  localparam logic [2:0] F3_FENCEI = 3'b001;

  // One instruction word seen through each of the six base formats
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_u;

endpackage

// File: source/rv32_config.svh
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// Width of the integer data path
`define RV32_XLEN 32

// Number of architectural registers
// Set to 16 for an RV32E-sized register file
`define RV32_NREGS 32

`endif
